// File: common/axis_tx_pkg.sv
/* Stream widths, MTU and queue sizing shared by the packet transmitter.
   DATA_BYTES and QUEUE_DEPTH must be powers of two, DATA_BYTES at least 2. */
`default_nettype none

package axis_tx_pkg;

    // Stream beat geometry.
    localparam int DATA_BYTES = 4;
    localparam int DATA_WIDTH = DATA_BYTES * 8;
    localparam int USER_WIDTH = 8;

    // Largest packet, and a length port wide enough to hold it.
    localparam int MTU_BYTES = 64;
    localparam int LEN_WIDTH = $clog2(MTU_BYTES + 1);

    localparam int MAX_BEATS = MTU_BYTES / DATA_BYTES;
    localparam int BEAT_IDX_WIDTH = $clog2(MAX_BEATS); // Index of a beat in a packet.
    localparam int LANE_IDX_WIDTH = $clog2(DATA_BYTES); // Byte lane within a beat.

    // Beat queue in the stream driver.
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH = QUEUE_PTR_WIDTH + 1; // Holds 0 to QUEUE_DEPTH.

    typedef enum logic [0:0] {
        gen_idle = 1'b0, // Waiting for a request.
        gen_emit = 1'b1  // Writing beats into the driver queue.
    } gen_state_t;

endpackage

`default_nettype wire

// File: axis_packet_generator/axis_packet_generator.sv
/* Requests with a length of 0 or above MTU_BYTES are dropped and busy stays low.
   Lanes are little endian, byte k of the packet leaves in lane k mod DATA_BYTES. */
`timescale 1ns/1ps
`default_nettype none

module axis_packet_generator (
    input  var logic                                        axis_packet_out,
    input  var logic                                        reset,

    input  var logic                                        send_packet_req,
    input  var logic [axis_tx_pkg::LEN_WIDTH-1:0]           packet_byte_length,
    input  var logic [axis_tx_pkg::USER_WIDTH-1:0]          packet_user,
    input  var logic [axis_tx_pkg::MTU_BYTES*8-1:0]         packet_data,
    output var logic                                        busy,

    input  var logic                                        queue_full,
    output var logic                                        beat_valid,
    output var logic [axis_tx_pkg::DATA_WIDTH-1:0]          beat_data,
    output var logic [axis_tx_pkg::DATA_BYTES-1:0]          beat_keep,
    output var logic                                        beat_last,
    output var logic [axis_tx_pkg::USER_WIDTH-1:0]          beat_user
);

    import axis_tx_pkg::*;

    gen_state_t                     state;
    logic                           len_ok;
    logic                           accept;

    // Packet held for the whole emit phase.
    logic [MTU_BYTES*8-1:0]         data_q;
    logic [USER_WIDTH-1:0]          user_q;
    logic [LEN_WIDTH-1:0]           len_q;
    logic [BEAT_IDX_WIDTH-1:0]      last_idx;

    logic [BEAT_IDX_WIDTH-1:0]      beat_idx;
    logic [LANE_IDX_WIDTH-1:0]      tail_bytes;

    assign len_ok = (packet_byte_length != '0) &&
                    (packet_byte_length <= LEN_WIDTH'(MTU_BYTES));
    assign accept = (state == gen_idle) && send_packet_req && len_ok;

    assign busy = (state == gen_emit);

    always_ff @(posedge axis_packet_out) begin
        if (reset) begin
            state    <= gen_idle;
            beat_idx <= '0;
        end else begin
            case (state)
                gen_idle: begin
                    if (accept) begin
                        state    <= gen_emit;
                        beat_idx <= '0;
                    end
                end
                gen_emit: begin
                    if (beat_valid) begin
                        if (beat_last) begin
                            state <= gen_idle; // Final beat queued.
                        end else begin
                            beat_idx <= beat_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= gen_idle;
                end
            endcase
        end
    end

    // Capture the request on acceptance only.
    always_ff @(posedge axis_packet_out) begin
        if (accept) begin
            data_q   <= packet_data;
            user_q   <= packet_user;
            len_q    <= packet_byte_length;
            last_idx <= BEAT_IDX_WIDTH'((packet_byte_length - 1'b1) / DATA_BYTES);
        end
    end

    // One beat per cycle while the driver has room.
    assign beat_valid = (state == gen_emit) && !queue_full;
    assign beat_last  = (beat_idx == last_idx);
    assign beat_user  = user_q;

    // Beat w covers bytes w*DATA_BYTES upward, lowest byte in lane 0.
    assign beat_data = data_q[beat_idx*DATA_WIDTH +: DATA_WIDTH];

    assign tail_bytes = len_q[LANE_IDX_WIDTH-1:0]; // Length mod DATA_BYTES.

    always_comb begin
        for (int lane = 0; lane < DATA_BYTES; lane++) begin
            if (!beat_last || tail_bytes == '0) begin
                beat_keep[lane] = 1'b1;
            end else begin
                beat_keep[lane] = (LANE_IDX_WIDTH'(lane) < tail_bytes); // Partial tail.
            end
        end
    end

endmodule

`default_nettype wire

// File: axis_packet_generator/axis_stream_driver.sv
/* Beats leave one cycle after they are written, through a registered output stage.
   The generator must not write while queue_full is high. */
`timescale 1ns/1ps
`default_nettype none

module axis_stream_driver (
    input  var logic                                        axis_packet_out,
    input  var logic                                        reset,

    input  var logic                                        beat_valid,
    input  var logic [axis_tx_pkg::DATA_WIDTH-1:0]          beat_data,
    input  var logic [axis_tx_pkg::DATA_BYTES-1:0]          beat_keep,
    input  var logic                                        beat_last,
    input  var logic [axis_tx_pkg::USER_WIDTH-1:0]          beat_user,
    output var logic                                        queue_full,

    output var logic                                        tvalid,
    input  var logic                                        tready,
    output var logic [axis_tx_pkg::DATA_WIDTH-1:0]          tdata,
    output var logic [axis_tx_pkg::DATA_BYTES-1:0]          tkeep,
    output var logic                                        tlast,
    output var logic [axis_tx_pkg::USER_WIDTH-1:0]          tuser
);

    import axis_tx_pkg::*;

    logic [DATA_WIDTH-1:0]          mem_data [QUEUE_DEPTH];
    logic [DATA_BYTES-1:0]          mem_keep [QUEUE_DEPTH];
    logic                           mem_last [QUEUE_DEPTH];
    logic [USER_WIDTH-1:0]          mem_user [QUEUE_DEPTH];

    logic [QUEUE_PTR_WIDTH-1:0]     wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0]     rd_ptr;
    logic [QUEUE_CNT_WIDTH-1:0]     count;

    logic                           push;
    logic                           pop;

    assign queue_full = (count == QUEUE_CNT_WIDTH'(QUEUE_DEPTH));
    assign push       = beat_valid && !queue_full;

    // Head moves to the output when it is empty or being taken.
    assign pop = (count != '0) && (!tvalid || tready);

    always_ff @(posedge axis_packet_out) begin
        if (push) begin
            mem_data[wr_ptr] <= beat_data;
            mem_keep[wr_ptr] <= beat_keep;
            mem_last[wr_ptr] <= beat_last;
            mem_user[wr_ptr] <= beat_user;
        end
    end

    always_ff @(posedge axis_packet_out) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at QUEUE_DEPTH.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Output stage holds still while tvalid is high and tready is low.
    always_ff @(posedge axis_packet_out) begin
        if (reset) begin
            tvalid <= 1'b0;
        end else if (!tvalid || tready) begin
            tvalid <= (count != '0);
        end
    end

    always_ff @(posedge axis_packet_out) begin
        if (pop) begin
            tdata <= mem_data[rd_ptr];
            tkeep <= mem_keep[rd_ptr];
            tlast <= mem_last[rd_ptr];
            tuser <= mem_user[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: design/axis_packet_tx_top.sv
/* Busy covers acceptance up to the queuing of the last beat, not its transfer.
   With tready high a packet leaves in consecutive cycles, tvalid two cycles after acceptance. */
`timescale 1ns/1ps
`default_nettype none

module axis_packet_tx_top (
    input  var logic                                        axis_packet_out,
    input  var logic                                        reset,

    input  var logic                                        send_packet_req,
    input  var logic [axis_tx_pkg::LEN_WIDTH-1:0]           packet_byte_length,
    input  var logic [axis_tx_pkg::USER_WIDTH-1:0]          packet_user,
    input  var logic [axis_tx_pkg::MTU_BYTES*8-1:0]         packet_data,
    output var logic                                        busy,

    output var logic                                        tvalid,
    input  var logic                                        tready,
    output var logic [axis_tx_pkg::DATA_WIDTH-1:0]          tdata,
    output var logic [axis_tx_pkg::DATA_BYTES-1:0]          tkeep,
    output var logic                                        tlast,
    output var logic [axis_tx_pkg::USER_WIDTH-1:0]          tuser
);

    import axis_tx_pkg::*;

    logic                           beat_valid;
    logic [DATA_WIDTH-1:0]          beat_data;
    logic [DATA_BYTES-1:0]          beat_keep;
    logic                           beat_last;
    logic [USER_WIDTH-1:0]          beat_user;
    logic                           queue_full;

    axis_packet_generator axis_packet_generator_inst (
        .axis_packet_out    (axis_packet_out),
        .reset              (reset),
        .send_packet_req    (send_packet_req),
        .packet_byte_length (packet_byte_length),
        .packet_user        (packet_user),
        .packet_data        (packet_data),
        .busy               (busy),
        .queue_full         (queue_full),
        .beat_valid         (beat_valid),
        .beat_data          (beat_data),
        .beat_keep          (beat_keep),
        .beat_last          (beat_last),
        .beat_user          (beat_user)
    );

    axis_stream_driver axis_stream_driver_inst (
        .axis_packet_out    (axis_packet_out),
        .reset              (reset),
        .beat_valid         (beat_valid),
        .beat_data          (beat_data),
        .beat_keep          (beat_keep),
        .beat_last          (beat_last),
        .beat_user          (beat_user),
        .queue_full         (queue_full),
        .tvalid             (tvalid),
        .tready             (tready),
        .tdata              (tdata),
        .tkeep              (tkeep),
        .tlast              (tlast),
        .tuser              (tuser)
    );

endmodule

`default_nettype wire

// File: test/axis_clock_gen.sv
/* Free-running 8 ns clock, reset held high for the first 16 rising edges. */
`timescale 1ns/1ps
`default_nettype none

module axis_clock_gen (
    output logic axis_packet_out,
    output logic reset
);

    initial begin
        axis_packet_out = 1'b0;
        forever #4 axis_packet_out = ~axis_packet_out;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge axis_packet_out);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: test/axis_stream_checker.sv
/* Predicts beats from requests seen at the DUT ports and compares each transfer.
   Also checks reset idle levels and the two-cycle latency into an empty queue. */
`timescale 1ns/1ps
`default_nettype none

module axis_stream_checker (
    input  wire logic                                       axis_packet_out,
    input  wire logic                                       reset,
    input  wire logic                                       send_packet_req,
    input  wire logic [axis_tx_pkg::LEN_WIDTH-1:0]          packet_byte_length,
    input  wire logic [axis_tx_pkg::USER_WIDTH-1:0]         packet_user,
    input  wire logic [axis_tx_pkg::MTU_BYTES*8-1:0]        packet_data,
    input  wire logic                                       busy,
    input  wire logic                                       tvalid,
    input  wire logic                                       tready,
    input  wire logic [axis_tx_pkg::DATA_WIDTH-1:0]         tdata,
    input  wire logic [axis_tx_pkg::DATA_BYTES-1:0]         tkeep,
    input  wire logic                                       tlast,
    input  wire logic [axis_tx_pkg::USER_WIDTH-1:0]         tuser,
    output int                                              error_count,
    output int                                              beat_count,
    output int                                              pending
);

    import axis_tx_pkg::*;

    logic [DATA_WIDTH-1:0] exp_data[$];
    logic [DATA_BYTES-1:0] exp_keep[$];
    logic                  exp_last[$];
    logic [USER_WIDTH-1:0] exp_user[$];
    logic                  started = 1'b0;
    logic                  mid_packet = 1'b0; // Non-final beat just transferred.
    int                    lat_step = 0;   // Latency probe after acceptance.

    initial begin
        error_count = 0;
        beat_count  = 0;
    end

    assign pending = exp_data.size();

    task automatic push_packet();
        int nb;
        int rem;
        logic [DATA_WIDTH-1:0] d;
        nb  = (int'(packet_byte_length) + DATA_BYTES - 1) / DATA_BYTES;
        rem = int'(packet_byte_length) % DATA_BYTES;
        for (int b = 0; b < nb; b++) begin
            for (int l = 0; l < DATA_BYTES; l++) begin
                d[l*8 +: 8] = packet_data[(b*DATA_BYTES + l)*8 +: 8]; // Little endian.
            end
            exp_data.push_back(d);
            exp_user.push_back(packet_user);
            exp_last.push_back(b == nb - 1);
            if (b == nb - 1 && rem != 0) begin
                exp_keep.push_back(DATA_BYTES'((1 << rem) - 1));
            end else begin
                exp_keep.push_back('1);
            end
        end
    endtask

    task automatic compare_beat();
        beat_count++;
        if (exp_data.size() == 0) begin
            $display("unexpected beat transferred with no packet pending");
            error_count++;
            return;
        end
        if (tdata !== exp_data[0]) begin
            $display("error tdata exp 0x%h got 0x%h", exp_data[0], tdata);
            error_count++;
        end
        if (tkeep !== exp_keep[0]) begin
            $display("error tkeep exp 0x%h got 0x%h", exp_keep[0], tkeep);
            error_count++;
        end
        if (tlast !== exp_last[0]) begin
            $display("error tlast exp 0x%h got 0x%h", exp_last[0], tlast);
            error_count++;
        end
        if (tuser !== exp_user[0]) begin
            $display("error tuser exp 0x%h got 0x%h", exp_user[0], tuser);
            error_count++;
        end
        void'(exp_data.pop_front());
        void'(exp_keep.pop_front());
        void'(exp_last.pop_front());
        void'(exp_user.pop_front());
    endtask

    always @(posedge axis_packet_out) begin
        if (!reset) begin
            if (!started && busy !== 1'b0) begin
                $display("error busy exp 0x0 got 0x%h", busy);
                error_count++;
            end
            if (!started && tvalid !== 1'b0) begin
                $display("error tvalid exp 0x0 got 0x%h", tvalid);
                error_count++;
            end
            case (lat_step)
                1: if (busy !== 1'b1) begin
                    $display("error busy exp 0x1 got 0x%h", busy);
                    error_count++;
                end
                2: if (tvalid !== 1'b0) begin
                    $display("error tvalid exp 0x0 got 0x%h", tvalid);
                    error_count++;
                end
                3: if (tvalid !== 1'b1) begin
                    $display("error tvalid exp 0x1 got 0x%h", tvalid);
                    error_count++;
                end
                default: ;
            endcase
            lat_step = (lat_step == 0 || lat_step == 3) ? 0 : lat_step + 1;
            // Beats of one packet follow without a gap.
            if (mid_packet && tvalid !== 1'b1) begin
                $display("error tvalid exp 0x1 got 0x%h", tvalid);
                error_count++;
            end
            mid_packet = tvalid && tready && !tlast;
            if (tvalid && tready) begin
                compare_beat();
            end
            if (send_packet_req && !busy && packet_byte_length >= 1 &&
                packet_byte_length <= MTU_BYTES) begin
                if (exp_data.size() == 0 && !tvalid) begin
                    lat_step = 1;
                end
                started = 1'b1;
                push_packet();
            end
        end
    end

endmodule

`default_nettype wire

// File: test/axis_packet_tx_sva.sv
/* Stream stability, reset, queue occupancy and busy assertions, bound into the top level. */
`timescale 1ns/1ps
`default_nettype none

module axis_packet_tx_sva (
    input wire logic                                        axis_packet_out,
    input wire logic                                        reset,
    input wire logic                                        tvalid,
    input wire logic                                        tready,
    input wire logic [axis_tx_pkg::DATA_WIDTH-1:0]          tdata,
    input wire logic [axis_tx_pkg::DATA_BYTES-1:0]          tkeep,
    input wire logic                                        tlast,
    input wire logic [axis_tx_pkg::USER_WIDTH-1:0]          tuser,
    input wire logic                                        beat_valid,
    input wire logic                                        beat_last,
    input wire logic [axis_tx_pkg::QUEUE_CNT_WIDTH-1:0]     count,
    input wire logic                                        busy,
    input wire axis_tx_pkg::gen_state_t                     state
);

    import axis_tx_pkg::*;

    int failures = 0;

    stream_stable: assert property (@(posedge axis_packet_out) disable iff (reset)
        tvalid && !tready |=> tvalid && $stable({tdata, tkeep, tlast, tuser}))
        else begin failures++; $error("stream changed while stalled"); end

    idle_after_reset: assert property (@(posedge axis_packet_out) reset |=> !tvalid)
        else begin failures++; $error("tvalid high after reset"); end

    // Writes only land while the queue holds fewer than QUEUE_DEPTH beats.
    no_write_when_full: assert property (@(posedge axis_packet_out) disable iff (reset)
        beat_valid |-> count < QUEUE_CNT_WIDTH'(QUEUE_DEPTH))
        else begin failures++; $error("beat written into a full queue"); end

    busy_until_last: assert property (@(posedge axis_packet_out) disable iff (reset)
        state == gen_emit |=> busy == !$past(beat_valid && beat_last))
        else begin failures++; $error("busy did not follow the queuing of the last beat"); end

endmodule

bind axis_packet_tx_top axis_packet_tx_sva axis_packet_tx_sva_inst (
    .axis_packet_out (axis_packet_out),
    .reset           (reset),
    .tvalid          (axis_stream_driver_inst.tvalid),
    .tready          (axis_stream_driver_inst.tready),
    .tdata           (axis_stream_driver_inst.tdata),
    .tkeep           (axis_stream_driver_inst.tkeep),
    .tlast           (axis_stream_driver_inst.tlast),
    .tuser           (axis_stream_driver_inst.tuser),
    .beat_valid      (axis_packet_generator_inst.beat_valid),
    .beat_last       (axis_packet_generator_inst.beat_last),
    .count           (axis_stream_driver_inst.count),
    .busy            (axis_packet_generator_inst.busy),
    .state           (axis_packet_generator_inst.state)
);

`default_nettype wire

// File: test/tb_axis_packet_tx.sv
/* Runs the packets listed in test/packet_input.txt, one at a time.
   The simulator must be started from the project root to find that file. */
`timescale 1ns/1ps
`default_nettype none

module tb_axis_packet_tx;

    import axis_tx_pkg::*;

    logic                    axis_packet_out;
    logic                    reset;
    logic                    send_packet_req = 1'b0;
    logic [LEN_WIDTH-1:0]    packet_byte_length = '0;
    logic [USER_WIDTH-1:0]   packet_user = '0;
    logic [MTU_BYTES*8-1:0]  packet_data = '0;
    logic                    busy;
    logic                    tvalid;
    logic                    tready = 1'b1;
    logic [DATA_WIDTH-1:0]   tdata;
    logic [DATA_BYTES-1:0]   tkeep;
    logic                    tlast;
    logic [USER_WIDTH-1:0]   tuser;
    logic                    rand_mode = 1'b0;
    int                      error_count;
    int                      beat_count;
    int                      pending;
    int                      total_errors;
    int                      cycles = 0;
    int                      cycle_limit = 100;

    int len_q[$];
    int user_q[$];
    int first_q[$];
    int mode_q[$];

    axis_clock_gen axis_clock_gen_inst (.axis_packet_out(axis_packet_out), .reset(reset));

    axis_packet_tx_top axis_packet_tx_top_inst (.*);

    axis_stream_checker axis_stream_checker_inst (.*);

    always @(posedge axis_packet_out) begin
        tready <= rand_mode ? 1'(($urandom) & 1) : 1'b1;
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: stream stalled");
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic read_input();
        int    fd;
        int    n;
        int    len;
        int    user;
        int    first;
        int    mode;
        string line;
        fd = $fopen("test/packet_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the input file");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %h %d", len, user, first, mode);
                    if (n == 4) begin
                        len_q.push_back(len);
                        user_q.push_back(user);
                        first_q.push_back(first);
                        mode_q.push_back(mode);
                        cycle_limit += 8 * ((len >= 1 && len <= MTU_BYTES ?
                                       (len + DATA_BYTES - 1) / DATA_BYTES : 0) + 4);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_line(input int idx);
        logic [MTU_BYTES*8-1:0] d;
        logic                   valid_len;
        for (int k = 0; k < MTU_BYTES; k++) begin
            d[k*8 +: 8] = 8'((first_q[idx] + k) % 256);
        end
        valid_len = len_q[idx] >= 1 && len_q[idx] <= MTU_BYTES;
        while (busy) @(posedge axis_packet_out);
        rand_mode          <= (mode_q[idx] == 1);
        send_packet_req    <= 1'b1;
        packet_byte_length <= LEN_WIDTH'(len_q[idx]);
        packet_user        <= USER_WIDTH'(user_q[idx]);
        packet_data        <= d;
        @(posedge axis_packet_out);
        // A second request lands while busy is high and must be ignored.
        send_packet_req    <= valid_len;
        packet_byte_length <= LEN_WIDTH'(4);
        packet_user        <= ~USER_WIDTH'(user_q[idx]);
        @(posedge axis_packet_out);
        send_packet_req    <= 1'b0;
        if (valid_len) begin
            @(posedge axis_packet_out);
            while (!(tvalid && tready && tlast)) @(posedge axis_packet_out);
        end else begin
            repeat (4) @(posedge axis_packet_out);
        end
    endtask

    initial begin
        void'($urandom(32'h3629_bf55));
        read_input();
        @(posedge axis_packet_out);
        while (reset) @(posedge axis_packet_out);
        repeat (3) @(posedge axis_packet_out);
        for (int i = 0; i < len_q.size(); i++) begin
            send_line(i);
        end
        repeat (8) @(posedge axis_packet_out);
        total_errors = error_count + axis_packet_tx_top_inst.axis_packet_tx_sva_inst.failures;
        if (pending != 0) begin
            $display("%0d expected beats were never sent", pending);
            total_errors++;
        end
        $display("errors %0d beats %0d", total_errors, beat_count);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/packet_input.txt
# length(dec) user(hex) first_byte(hex) tready_mode(0 high, 1 random)
1 a1 10 0
4 a2 20 0
5 a3 30 0
7 a4 fe 0
63 a5 40 0
64 a6 c0 0
0 b1 50 0
65 b2 60 0
13 c1 70 1
64 c2 80 1
3 c3 f0 1
17 c4 90 1
8 d1 05 0

// File: tb.f
common/axis_tx_pkg.sv
axis_packet_generator/axis_packet_generator.sv
axis_packet_generator/axis_stream_driver.sv
design/axis_packet_tx_top.sv
test/axis_clock_gen.sv
test/axis_stream_checker.sv
test/axis_packet_tx_sva.sv
test/tb_axis_packet_tx.sv
